// File: dv/mem2rw_monitor.sv
`default_nettype none

`include "mem2rw_defines.svh"

module mem2rw_monitor (
  input  logic              clk,
  input  logic              rst,
  input  logic [1:0]        read,
  input  logic [1:0]        write,
  input  mem2rw_pkg::addr_t addr [2],
  input  mem2rw_pkg::data_t din [2],
  output logic              exp_ready,
  output logic [1:0]        exp_vld,
  output mem2rw_pkg::data_t exp_dout [2],
  output logic [1:0]        exp_fwrd,
  output mem2rw_pkg::padr_t exp_padr [2],
  output logic              busy
);

  timeunit 1ns;
  timeprecision 100ps;

  import mem2rw_pkg::*;

  // Queue entry holds the due cycle, the forward flag, the physical address and the data
  localparam int EW = 32 + 1 + `MEM_BITPADR + `MEM_WIDTH;

  data_t         model [`MEM_NUMADDR];
  logic [EW-1:0] pend0 [$];
  logic [EW-1:0] pend1 [$];
  int            cyc;

  function automatic padr_t phys_addr(input addr_t a);
    int bank;
    int row;
    bank = int'(a) % `MEM_NUMVBNK;
    row  = int'(a) / `MEM_NUMVBNK;
    return {bank[`MEM_BITVBNK-1:0], row[`MEM_BITVROW-1:0]};
  endfunction

  function automatic logic [EW-1:0] make_entry(input int due, input logic fw,
                                               input padr_t pa, input data_t d);
    return {32'(due), fw, pa, d};
  endfunction

  always @(posedge clk) begin : step
    logic          acc;
    logic          fw;
    data_t         rdat;
    int            due;
    logic          has [2];
    logic [EW-1:0] head [2];

    // Results shown in the cycle that just ended leave the queues
    if (pend0.size() > 0 && int'(pend0[0][EW-1 -: 32]) == cyc) void'(pend0.pop_front());
    if (pend1.size() > 0 && int'(pend1[0][EW-1 -: 32]) == cyc) void'(pend1.pop_front());
    cyc = cyc + 1;
    acc = exp_ready;
    exp_ready = !rst;
    // A request sampled at this edge is answered after MEM_SRAM_DELAY - 1 more edges
    due = cyc + `MEM_SRAM_DELAY - 1;
    if (rst) begin
      pend0.delete();
      pend1.delete();
    end else if (acc) begin
      for (int p = 0; p < 2; p++) begin
        if (read[p]) begin
          fw   = write[1-p] && (addr[1-p] == addr[p]);
          rdat = fw ? din[1-p] : model[addr[p]];
          if (p == 0) pend0.push_back(make_entry(due, fw, phys_addr(addr[p]), rdat));
          else pend1.push_back(make_entry(due, fw, phys_addr(addr[p]), rdat));
        end
      end
      // Port 1 goes last so it wins a collision
      if (write[0]) model[addr[0]] = din[0];
      if (write[1]) model[addr[1]] = din[1];
    end
    has[0]  = pend0.size() > 0;
    has[1]  = pend1.size() > 0;
    head[0] = has[0] ? pend0[0] : '0;
    head[1] = has[1] ? pend1[0] : '0;
    for (int p = 0; p < 2; p++) begin
      exp_vld[p]  = has[p] && (int'(head[p][EW-1 -: 32]) == cyc);
      exp_fwrd[p] = head[p][`MEM_WIDTH + `MEM_BITPADR];
      exp_padr[p] = head[p][`MEM_WIDTH +: `MEM_BITPADR];
      exp_dout[p] = head[p][`MEM_WIDTH-1:0];
    end
    busy = has[0] || has[1];
  end

endmodule

`default_nettype wire

// File: dv/mem2rw_tb.sv
`default_nettype none

`include "mem2rw_defines.svh"

module mem2rw_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import mem2rw_pkg::*;

  localparam int CLK_PERIOD = 4;
  // Reset, fill with write/read, random traffic, collision, forwarding and bank spread
  localparam int STIM_CYCLES = 6 + 300 + 2020 + 8 * 24 + 8 * 24 + 12 * 14;
  localparam int WATCHDOG_NS = 2 * STIM_CYCLES * CLK_PERIOD;

  logic       clk = 1'b0;
  logic       rst;
  logic [1:0] read;
  logic [1:0] write;
  addr_t      addr [2];
  data_t      din [2];
  logic       ready;
  logic [1:0] rd_vld;
  data_t      rd_dout [2];
  logic [1:0] rd_fwrd;
  padr_t      rd_padr [2];
  logic       exp_ready;
  logic [1:0] exp_vld;
  data_t      exp_dout [2];
  logic [1:0] exp_fwrd;
  padr_t      exp_padr [2];
  logic       busy;

  int    seed = 6;
  int    errors = 0;
  int    test_errors = 0;
  int    checks = 0;
  int    tests_run = 0;
  string test_name = "reset";

  mem2rw_top UUT (
    .clk     (clk),
    .rst     (rst),
    .read    (read),
    .write   (write),
    .addr    (addr),
    .din     (din),
    .ready   (ready),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout),
    .rd_fwrd (rd_fwrd),
    .rd_padr (rd_padr)
  );

  mem2rw_monitor u_monitor (
    .clk       (clk),
    .rst       (rst),
    .read      (read),
    .write     (write),
    .addr      (addr),
    .din       (din),
    .exp_ready (exp_ready),
    .exp_vld   (exp_vld),
    .exp_dout  (exp_dout),
    .exp_fwrd  (exp_fwrd),
    .exp_padr  (exp_padr),
    .busy      (busy)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  function automatic addr_t rand_addr();
    return addr_t'($unsigned($random(seed)) % `MEM_NUMADDR);
  endfunction

  function automatic data_t rand_data();
    return data_t'($random(seed));
  endfunction

  function automatic padr_t padr_of(input addr_t a);
    int bank;
    int row;
    bank = int'(a) % `MEM_NUMVBNK;
    row  = int'(a) / `MEM_NUMVBNK;
    return {bank[`MEM_BITVBNK-1:0], row[`MEM_BITVROW-1:0]};
  endfunction

  task automatic drive_ports(input logic [1:0] rd, input logic [1:0] wr, input addr_t a0,
                             input addr_t a1, input data_t d0, input data_t d1);
    @(negedge clk);
    read    = rd;
    write   = wr;
    addr[0] = a0;
    addr[1] = a1;
    din[0]  = d0;
    din[1]  = d1;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    drive_ports(2'b00, 2'b00, '0, '0, '0, '0);
    while (busy && n < 4 * `MEM_SRAM_DELAY) begin
      @(negedge clk);
      n++;
    end
    if (busy) begin
      $display("Read results were still pending when %s ended", test_name);
      errors++;
      test_errors++;
    end
  endtask

  // Waits from the current falling edge for a read result on port p and checks it
  task automatic await_read(input int p, input data_t d, input logic fw, input padr_t pa);
    int n;
    n = 0;
    while (!rd_vld[p] && n < 4 * `MEM_SRAM_DELAY) begin
      @(negedge clk);
      n++;
    end
    if (!rd_vld[p]) begin
      $display("No read result arrived on port %0d during %s", p, test_name);
      errors++;
      test_errors++;
    end else begin
      check_value({test_name, " rd_dout"}, 32'(d), 32'(rd_dout[p]));
      check_value({test_name, " rd_fwrd"}, 32'(fw), 32'(rd_fwrd[p]));
      check_value({test_name, " rd_padr"}, 32'(pa), 32'(rd_padr[p]));
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    $display("Test %0d %s finished with %0d errors", tests_run, test_name, test_errors);
  endtask

  // Every cycle the outputs are compared with the monitor's model
  always @(negedge clk) begin
    check_value({test_name, " ready"}, 32'(exp_ready), 32'(ready));
    for (int p = 0; p < 2; p++) begin
      check_value($sformatf("%s port%0d rd_vld", test_name, p), 32'(exp_vld[p]),
                  32'(rd_vld[p]));
      if (exp_vld[p]) begin
        check_value($sformatf("%s port%0d rd_dout", test_name, p), 32'(exp_dout[p]),
                    32'(rd_dout[p]));
        check_value($sformatf("%s port%0d rd_fwrd", test_name, p), 32'(exp_fwrd[p]),
                    32'(rd_fwrd[p]));
        check_value($sformatf("%s port%0d rd_padr", test_name, p), 32'(exp_padr[p]),
                    32'(rd_padr[p]));
      end
    end
  end

  initial begin
    addr_t      a;
    data_t      d0;
    data_t      d1;
    logic [1:0] rd;
    logic [1:0] wr;
    addr_t      ra [2];
    data_t      rdat [2];
    int         op;
    addr_t      list_addr [32];
    data_t      list_data [12];

    rst     = 1'b1;
    read    = 2'b00;
    write   = 2'b00;
    addr[0] = '0;
    addr[1] = '0;
    din[0]  = '0;
    din[1]  = '0;

    start_test("reset");
    repeat (5) @(negedge clk);
    check_value("reset ready", 32'(0), 32'(ready));
    check_value("reset rd_vld", 32'(0), 32'(rd_vld));
    rst = 1'b0;
    @(negedge clk);
    check_value("reset ready", 32'(1), 32'(ready));
    finish_test();

    start_test("write_read");
    for (int i = 0; i < `MEM_NUMADDR / 2; i++) begin
      drive_ports(2'b00, 2'b11, addr_t'(i), addr_t'(i + `MEM_NUMADDR / 2),
                  rand_data(), rand_data());
    end
    for (int i = 0; i < 32; i++) begin
      list_addr[i] = rand_addr();
      d0 = rand_data();
      drive_ports(2'b00, (i % 2 == 0) ? 2'b01 : 2'b10, list_addr[i], list_addr[i], d0, d0);
    end
    for (int i = 0; i < 32; i++) begin
      drive_ports(($random(seed) & 1) ? 2'b10 : 2'b01, 2'b00, list_addr[i], list_addr[i],
                  '0, '0);
    end
    wait_drain();
    finish_test();

    start_test("random_traffic");
    for (int i = 0; i < 2000; i++) begin
      for (int p = 0; p < 2; p++) begin
        op    = $unsigned($random(seed)) % 3;
        rd[p] = (op == 1);
        wr[p] = (op == 2);
        // A narrow window of addresses makes both ports meet often
        ra[p] = (($random(seed) & 3) == 0) ? addr_t'(rand_addr() % 8) : rand_addr();
        rdat[p] = rand_data();
      end
      drive_ports(rd, wr, ra[0], ra[1], rdat[0], rdat[1]);
    end
    wait_drain();
    finish_test();

    start_test("write_collision");
    for (int i = 0; i < 8; i++) begin
      a  = rand_addr();
      d0 = rand_data();
      d1 = rand_data();
      drive_ports(2'b00, 2'b11, a, a, d0, d1);
      drive_ports(2'b01, 2'b00, a, a, '0, '0);
      drive_ports(2'b00, 2'b00, a, a, '0, '0);
      await_read(0, d1, 1'b0, padr_of(a));
      drive_ports(2'b10, 2'b00, a, a, '0, '0);
      drive_ports(2'b00, 2'b00, a, a, '0, '0);
      await_read(1, d1, 1'b0, padr_of(a));
    end
    wait_drain();
    finish_test();

    start_test("forwarding");
    for (int i = 0; i < 8; i++) begin
      a  = rand_addr();
      d0 = rand_data();
      d1 = ~d0;
      rd = (i % 2 == 0) ? 2'b01 : 2'b10;
      // The reading port carries other data so only the writer's word can come back
      drive_ports(rd, ~rd, a, a, rd[0] ? d1 : d0, rd[0] ? d0 : d1);
      drive_ports(rd, 2'b00, a, a, '0, '0);
      drive_ports(2'b00, 2'b00, a, a, '0, '0);
      await_read(i % 2, d0, 1'b1, padr_of(a));
      drive_ports(2'b00, 2'b00, a, a, '0, '0);
      await_read(i % 2, d0, 1'b0, padr_of(a));
    end
    wait_drain();
    finish_test();

    start_test("bank_spread");
    // Row 0 and the highest row in every bank
    for (int i = 0; i < 12; i++) begin
      list_addr[i] = addr_t'((i < 6) ? i : `MEM_NUMADDR - 12 + i);
      list_data[i] = rand_data();
      drive_ports(2'b00, (i % 2 == 0) ? 2'b01 : 2'b10, list_addr[i], list_addr[i],
                  list_data[i], list_data[i]);
    end
    for (int i = 0; i < 12; i++) begin
      drive_ports((i % 2 == 0) ? 2'b10 : 2'b01, 2'b00, list_addr[i], list_addr[i], '0, '0);
      drive_ports(2'b00, 2'b00, list_addr[i], list_addr[i], '0, '0);
      await_read(1 - i % 2, list_data[i], 1'b0, padr_of(list_addr[i]));
    end
    wait_drain();
    finish_test();

    $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests finished, the run is stopped");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: include/mem2rw_defines.svh
`ifndef MEM2RW_DEFINES_SVH
`define MEM2RW_DEFINES_SVH

// Data word width
`define MEM_WIDTH 16

// Logical address space
`define MEM_NUMADDR 384
`define MEM_BITADDR 9

// Banks and rows per bank, the bank count need not be a power of two
`define MEM_NUMVBNK 6
`define MEM_BITVBNK 3
`define MEM_NUMVROW 64
`define MEM_BITVROW 6

// Physical address is the bank index above the row index
`define MEM_BITPADR 9

// Bank read latency in cycles
`define MEM_SRAM_DELAY 2

`endif

// File: mem2rw_top.f
+incdir+include
rtl/mem2rw_pkg.sv
rtl/vaddr_split.sv
rtl/bank_sram.sv
rtl/mem2rw_ctrl.sv
rtl/mem2rw_top.sv
dv/mem2rw_monitor.sv
dv/mem2rw_tb.sv

// File: rtl/bank_sram.sv
`default_nettype none

`include "mem2rw_defines.svh"

module bank_sram (
  input  logic              clk,
  input  logic              rst,
  input  logic              read_a,
  input  logic              write_a,
  input  mem2rw_pkg::vrow_t addr_a,
  input  mem2rw_pkg::data_t din_a,
  output mem2rw_pkg::data_t dout_a,
  input  logic              read_b,
  input  logic              write_b,
  input  mem2rw_pkg::vrow_t addr_b,
  input  mem2rw_pkg::data_t din_b,
  output mem2rw_pkg::data_t dout_b
);

  import mem2rw_pkg::*;

  localparam int LAST = `MEM_SRAM_DELAY - 1;

  data_t mem [`MEM_NUMVROW];

  logic  rd_en [2];
  vrow_t rd_row [2];
  data_t rd_out [2];

  assign rd_en[0]  = read_a;
  assign rd_en[1]  = read_b;
  assign rd_row[0] = addr_a;
  assign rd_row[1] = addr_b;

  // The controller never writes one row from both ports in the same cycle
  always_ff @(posedge clk) begin
    if (write_a) mem[addr_a] <= din_a;
    if (write_b) mem[addr_b] <= din_b;
  end

  for (genvar p = 0; p < 2; p++) begin : g_port
    data_t dly [`MEM_SRAM_DELAY];

    // Stage 0 samples the array, later stages only shift
    always_ff @(posedge clk) begin
      if (rst) begin
        for (int i = 0; i < `MEM_SRAM_DELAY; i++) dly[i] <= '0;
      end else begin
        dly[0] <= rd_en[p] ? mem[rd_row[p]] : '0;
        for (int i = 1; i < `MEM_SRAM_DELAY; i++) dly[i] <= dly[i-1];
      end
    end

    assign rd_out[p] = dly[LAST];
  end

  assign dout_a = rd_out[0];
  assign dout_b = rd_out[1];

endmodule

`default_nettype wire

// File: rtl/mem2rw_ctrl.sv
`default_nettype none

`include "mem2rw_defines.svh"

module mem2rw_ctrl (
  input  logic              clk,
  input  logic              rst,
  input  logic [1:0]        read,
  input  logic [1:0]        write,
  input  mem2rw_pkg::addr_t addr [2],
  input  mem2rw_pkg::data_t din [2],
  output logic              ready,
  output logic [1:0]        rd_vld,
  output mem2rw_pkg::data_t rd_dout [2],
  output logic [1:0]        rd_fwrd,
  output mem2rw_pkg::padr_t rd_padr [2],
  output logic              t1_read [`MEM_NUMVBNK][2],
  output logic              t1_write [`MEM_NUMVBNK][2],
  output mem2rw_pkg::vrow_t t1_addr [`MEM_NUMVBNK][2],
  output mem2rw_pkg::data_t t1_din [`MEM_NUMVBNK][2],
  input  mem2rw_pkg::data_t t1_dout [`MEM_NUMVBNK][2]
);

  import mem2rw_pkg::*;

  localparam int LAST = `MEM_SRAM_DELAY - 1;

  logic [1:0] rd_req;
  logic [1:0] wr_req;
  logic       same_addr;
  logic [1:0] wr_bank;
  logic [1:0] rd_bank;
  logic [1:0] fwd;
  vbnk_t      vbnk [2];
  vrow_t      vrow [2];

  // The memory comes up usable on the first cycle out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      ready <= 1'b0;
    end else begin
      ready <= 1'b1;
    end
  end

  assign rd_req    = read & {2{ready}};
  assign wr_req    = write & {2{ready}};
  assign same_addr = (addr[0] == addr[1]);

  for (genvar p = 0; p < 2; p++) begin : g_split
    vaddr_split u_split (
      .vaddr (addr[p]),
      .vbadr (vbnk[p]),
      .vradr (vrow[p])
    );
  end

  // Port 1 wins a write collision, port 0's write is dropped
  assign wr_bank[0] = wr_req[0] && !(wr_req[1] && same_addr);
  assign wr_bank[1] = wr_req[1];

  // A read that meets a write to its address takes the write data instead
  assign fwd[0]     = rd_req[0] && wr_req[1] && same_addr;
  assign fwd[1]     = rd_req[1] && wr_req[0] && same_addr;
  assign rd_bank    = rd_req & ~fwd;

  always_comb begin
    for (int b = 0; b < `MEM_NUMVBNK; b++) begin
      for (int p = 0; p < 2; p++) begin
        t1_read[b][p]  = rd_bank[p] && (vbnk[p] == vbnk_t'(b));
        t1_write[b][p] = wr_bank[p] && (vbnk[p] == vbnk_t'(b));
        t1_addr[b][p]  = vrow[p];
        t1_din[b][p]   = din[p];
      end
    end
  end

  for (genvar p = 0; p < 2; p++) begin : g_pipe
    logic  vld_q [`MEM_SRAM_DELAY];
    logic  fwd_q [`MEM_SRAM_DELAY];
    data_t fdat_q [`MEM_SRAM_DELAY];
    padr_t padr_q [`MEM_SRAM_DELAY];
    vbnk_t out_bnk;
    data_t bank_dout;

    always_ff @(posedge clk) begin
      if (rst) begin
        for (int i = 0; i < `MEM_SRAM_DELAY; i++) begin
          vld_q[i] <= 1'b0;
          fwd_q[i] <= 1'b0;
        end
      end else begin
        vld_q[0] <= rd_req[p];
        fwd_q[0] <= fwd[p];
        for (int i = 1; i < `MEM_SRAM_DELAY; i++) begin
          vld_q[i] <= vld_q[i-1];
          fwd_q[i] <= fwd_q[i-1];
        end
      end
    end

    // The forwarded word is the other port's write data
    always_ff @(posedge clk) begin
      fdat_q[0] <= din[1-p];
      padr_q[0] <= {vbnk[p], vrow[p]};
      for (int i = 1; i < `MEM_SRAM_DELAY; i++) begin
        fdat_q[i] <= fdat_q[i-1];
        padr_q[i] <= padr_q[i-1];
      end
    end

    assign out_bnk = padr_q[LAST][`MEM_BITPADR-1:`MEM_BITVROW];

    // Pick this port's output from the bank that was addressed
    always_comb begin
      bank_dout = '0;
      for (int b = 0; b < `MEM_NUMVBNK; b++) begin
        if (out_bnk == vbnk_t'(b)) bank_dout = t1_dout[b][p];
      end
    end

    assign rd_vld[p]  = vld_q[LAST];
    assign rd_fwrd[p] = vld_q[LAST] && fwd_q[LAST];
    assign rd_dout[p] = fwd_q[LAST] ? fdat_q[LAST] : bank_dout;
    assign rd_padr[p] = padr_q[LAST];
  end

endmodule

`default_nettype wire

// File: rtl/mem2rw_pkg.sv
`default_nettype none

`include "mem2rw_defines.svh"

package mem2rw_pkg;

  typedef logic [`MEM_WIDTH-1:0] data_t;

  typedef logic [`MEM_BITADDR-1:0] addr_t;

  typedef logic [`MEM_BITVBNK-1:0] vbnk_t;

  typedef logic [`MEM_BITVROW-1:0] vrow_t;

  // Bank in the upper bits, row in the lower bits
  typedef logic [`MEM_BITPADR-1:0] padr_t;

endpackage

`default_nettype wire

// File: rtl/mem2rw_top.sv
`default_nettype none

`include "mem2rw_defines.svh"

module mem2rw_top (
  input  logic              clk,
  input  logic              rst,
  input  logic [1:0]        read,
  input  logic [1:0]        write,
  input  mem2rw_pkg::addr_t addr [2],
  input  mem2rw_pkg::data_t din [2],
  output logic              ready,
  output logic [1:0]        rd_vld,
  output mem2rw_pkg::data_t rd_dout [2],
  output logic [1:0]        rd_fwrd,
  output mem2rw_pkg::padr_t rd_padr [2]
);

  import mem2rw_pkg::*;

  logic  t1_read [`MEM_NUMVBNK][2];
  logic  t1_write [`MEM_NUMVBNK][2];
  vrow_t t1_addr [`MEM_NUMVBNK][2];
  data_t t1_din [`MEM_NUMVBNK][2];
  data_t t1_dout [`MEM_NUMVBNK][2];

  mem2rw_ctrl u_ctrl (
    .clk      (clk),
    .rst      (rst),
    .read     (read),
    .write    (write),
    .addr     (addr),
    .din      (din),
    .ready    (ready),
    .rd_vld   (rd_vld),
    .rd_dout  (rd_dout),
    .rd_fwrd  (rd_fwrd),
    .rd_padr  (rd_padr),
    .t1_read  (t1_read),
    .t1_write (t1_write),
    .t1_addr  (t1_addr),
    .t1_din   (t1_din),
    .t1_dout  (t1_dout)
  );

  // Port p of the controller always lands on port p of the bank
  for (genvar b = 0; b < `MEM_NUMVBNK; b++) begin : g_bank
    bank_sram u_bank (
      .clk     (clk),
      .rst     (rst),
      .read_a  (t1_read[b][0]),
      .write_a (t1_write[b][0]),
      .addr_a  (t1_addr[b][0]),
      .din_a   (t1_din[b][0]),
      .dout_a  (t1_dout[b][0]),
      .read_b  (t1_read[b][1]),
      .write_b (t1_write[b][1]),
      .addr_b  (t1_addr[b][1]),
      .din_b   (t1_din[b][1]),
      .dout_b  (t1_dout[b][1])
    );
  end

endmodule

`default_nettype wire

// File: rtl/vaddr_split.sv
`default_nettype none

`include "mem2rw_defines.svh"

module vaddr_split (
  input  mem2rw_pkg::addr_t vaddr,
  output mem2rw_pkg::vbnk_t vbadr,
  output mem2rw_pkg::vrow_t vradr
);

  import mem2rw_pkg::*;

  // Consecutive addresses rotate across the banks, so the remainder picks the
  // bank and the quotient picks the row inside it
  logic [31:0] bank_full;
  logic [31:0] row_full;

  assign bank_full = 32'(vaddr) % `MEM_NUMVBNK;
  assign row_full  = 32'(vaddr) / `MEM_NUMVBNK;

  // Both results fit their fields for any address below MEM_NUMADDR
  assign vbadr = vbnk_t'(bank_full);
  assign vradr = vrow_t'(row_full);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -f mem2rw_top.f \
  --top-module mem2rw_tb -o mem2rw_sim \
  && ./obj_dir/mem2rw_sim | tee sim.log \
  && grep -qx "RESULT: PASS" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
